// File: common/decode_pkg.sv
`default_nettype none

package decode_pkg;

    typedef logic [31:0] xlen_t;       // pc, instruction word, immediate, npc
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  cond_t;       // branch funct3

    // kind of instruction after decode
    typedef enum logic [3:0] {
        op_none   = 4'd0,
        op_alu    = 4'd1,
        op_lui    = 4'd2,
        op_auipc  = 4'd3,
        op_jal    = 4'd4,
        op_jalr   = 4'd5,
        op_branch = 4'd6,
        op_load   = 4'd7,
        op_store  = 4'd8
    } op_class_t;

    // alu operation, also the comparison kind for branches
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_t;

    // initial slot contents
    localparam xlen_t     init_xlen     = '0;
    localparam reg_addr_t init_addr     = '0;
    localparam cond_t     init_cond     = '0;
    localparam op_class_t init_op_class = op_none;
    localparam alu_op_t   init_alu_op   = alu_add;

endpackage

`default_nettype wire

// File: hw/base_decoder.sv
`default_nettype none

module base_decoder (
    input  decode_pkg::xlen_t     instr,
    output logic                  dec_valid,
    output logic                  wren,
    output logic                  rden1,
    output logic                  rden2,
    output decode_pkg::op_class_t op_class,
    output decode_pkg::alu_op_t   alu_op,
    output decode_pkg::cond_t     cond,
    output decode_pkg::xlen_t     imm
);
    import decode_pkg::*;

    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       reg_form;   // register-register op
    logic       shift;
    logic       f7_zero;
    logic       alt;        // funct7 selects sub / sra
    logic       alu_ok;
    alu_op_t    alu_sel;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign reg_form = (opcode == opc_op);
    assign shift    = (funct3[1:0] == 2'b01);
    assign f7_zero  = (funct7 == 7'b0000000);
    assign alt      = (funct7 == 7'b0100000);

    // op-imm ignores funct7 except on shifts
    assign alu_ok = !(reg_form || shift) || f7_zero ||
                    (alt && (funct3 == 3'b101 || (reg_form && funct3 == 3'b000)));

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (funct3)
            3'b000:  alu_sel = (reg_form && alt) ? alu_sub : alu_add;
            3'b001:  alu_sel = alu_sll;
            3'b010:  alu_sel = alu_slt;
            3'b011:  alu_sel = alu_sltu;
            3'b100:  alu_sel = alu_xor;
            3'b101:  alu_sel = alt ? alu_sra : alu_srl;
            3'b110:  alu_sel = alu_or;
            default: alu_sel = alu_and;
        endcase
    end

    always_comb begin
        dec_valid = 1'b0;
        wren      = 1'b0;
        rden1     = 1'b0;
        rden2     = 1'b0;
        op_class  = init_op_class;
        alu_op    = init_alu_op;
        cond      = init_cond;
        imm       = init_xlen;
        case (opcode)
            opc_lui, opc_auipc: begin
                dec_valid = 1'b1;
                op_class  = (opcode == opc_lui) ? op_lui : op_auipc;
                imm       = imm_u;
                wren      = 1'b1;
            end
            opc_jal: begin
                dec_valid = 1'b1;
                op_class  = op_jal;
                imm       = imm_j;
                wren      = 1'b1;
            end
            opc_jalr: if (funct3 == 3'b000) begin
                dec_valid = 1'b1;
                op_class  = op_jalr;
                imm       = imm_i;
                wren      = 1'b1;
                rden1     = 1'b1;
            end
            opc_branch: if (funct3[2:1] != 2'b01) begin
                dec_valid = 1'b1;
                op_class  = op_branch;
                alu_op    = !funct3[2] ? alu_sub : (funct3[1] ? alu_sltu : alu_slt);
                cond      = funct3;
                imm       = imm_b;
                rden1     = 1'b1;
                rden2     = 1'b1;
            end
            opc_load, opc_store: if (funct3 == 3'b010) begin   // word access only
                dec_valid = 1'b1;
                op_class  = (opcode == opc_load) ? op_load : op_store;
                imm       = (opcode == opc_load) ? imm_i : imm_s;
                wren      = (opcode == opc_load);
                rden1     = 1'b1;
                rden2     = (opcode == opc_store);
            end
            opc_op_imm, opc_op: if (alu_ok) begin
                dec_valid = 1'b1;
                op_class  = op_alu;
                alu_op    = alu_sel;
                imm       = reg_form ? init_xlen : imm_i;
                wren      = 1'b1;
                rden1     = 1'b1;
                rden2     = reg_form;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/compress_decoder.sv
`default_nettype none

module compress_decoder (
    input  decode_pkg::xlen_t     instr,
    output logic                  dec_valid,
    output logic                  wren,
    output logic                  rden1,
    output logic                  rden2,
    output decode_pkg::op_class_t op_class,
    output decode_pkg::alu_op_t   alu_op,
    output decode_pkg::cond_t     cond,
    output decode_pkg::reg_addr_t waddr,
    output decode_pkg::reg_addr_t raddr1,
    output decode_pkg::reg_addr_t raddr2,
    output decode_pkg::xlen_t     imm
);
    import decode_pkg::*;

    logic [1:0] quad;
    logic [2:0] funct3;
    reg_addr_t  rd;        // rd / rs1 field
    reg_addr_t  rs2;
    reg_addr_t  rd_p;      // x8..x15
    reg_addr_t  rs1_p;
    xlen_t      imm_ci;
    xlen_t      imm_lsw;
    xlen_t      imm_j;
    xlen_t      imm_b;

    assign quad   = instr[1:0];
    assign funct3 = instr[15:13];
    assign rd     = instr[11:7];
    assign rs2    = instr[6:2];
    assign rd_p   = {2'b01, instr[4:2]};
    assign rs1_p  = {2'b01, instr[9:7]};

    assign imm_ci  = {{26{instr[12]}}, instr[12], instr[6:2]};
    assign imm_lsw = {25'b0, instr[5], instr[12:10], instr[6], 2'b00};   // word scaled
    assign imm_j   = {{20{instr[12]}}, instr[12], instr[8], instr[10:9], instr[6],
                      instr[7], instr[2], instr[11], instr[5:3], 1'b0};
    assign imm_b   = {{23{instr[12]}}, instr[12], instr[6:5], instr[2], instr[11:10],
                      instr[4:3], 1'b0};

    always_comb begin
        dec_valid = 1'b0;
        wren      = 1'b0;
        rden1     = 1'b0;
        rden2     = 1'b0;
        op_class  = init_op_class;
        alu_op    = init_alu_op;
        cond      = init_cond;
        waddr     = init_addr;
        raddr1    = init_addr;
        raddr2    = init_addr;
        imm       = init_xlen;
        // quadrant 11 is a 32-bit word and never matches
        case ({quad, funct3})
            5'b00_010: begin    // c.lw
                dec_valid = 1'b1;
                op_class  = op_load;
                waddr     = rd_p;
                raddr1    = rs1_p;
                imm       = imm_lsw;
                wren      = 1'b1;
                rden1     = 1'b1;
            end
            5'b00_110: begin    // c.sw
                dec_valid = 1'b1;
                op_class  = op_store;
                raddr1    = rs1_p;
                raddr2    = rd_p;
                imm       = imm_lsw;
                rden1     = 1'b1;
                rden2     = 1'b1;
            end
            5'b01_000, 5'b01_010: begin    // c.addi / c.nop, c.li reads x0
                dec_valid = 1'b1;
                op_class  = op_alu;
                waddr     = rd;
                raddr1    = (funct3 == 3'b000) ? rd : init_addr;
                imm       = imm_ci;
                wren      = 1'b1;
                rden1     = 1'b1;
            end
            5'b01_101: begin    // c.j, jal x0
                dec_valid = 1'b1;
                op_class  = op_jal;
                imm       = imm_j;
                wren      = 1'b1;
            end
            5'b01_110: begin    // c.beqz against x0
                dec_valid = 1'b1;
                op_class  = op_branch;
                alu_op    = alu_sub;
                cond      = 3'b000;
                raddr1    = rs1_p;
                imm       = imm_b;
                rden1     = 1'b1;
                rden2     = 1'b1;
            end
            5'b10_100: if (rs2 != 5'd0) begin    // c.mv, or c.add when bit 12 set
                dec_valid = 1'b1;
                op_class  = op_alu;
                waddr     = rd;
                raddr1    = instr[12] ? rd : init_addr;
                raddr2    = rs2;
                wren      = 1'b1;
                rden1     = 1'b1;
                rden2     = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: decode_stage/decode_stage.sv
`default_nettype none

module decode_stage #(
    parameter decode_pkg::xlen_t invalid_pc = '1
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  clear,
    input  logic                  ready0, ready1,
    input  decode_pkg::xlen_t     pc0, pc1,
    input  decode_pkg::xlen_t     instr0, instr1,
    output logic                  valid0, valid1,
    output logic                  exception0, exception1,
    output decode_pkg::op_class_t op_class0, op_class1,
    output decode_pkg::alu_op_t   alu_op0, alu_op1,
    output decode_pkg::cond_t     cond0, cond1,
    output decode_pkg::reg_addr_t waddr0, waddr1,
    output decode_pkg::reg_addr_t raddr10, raddr11,
    output decode_pkg::reg_addr_t raddr20, raddr21,
    output logic                  wren0, wren1,
    output logic                  rden10, rden11,
    output logic                  rden20, rden21,
    output decode_pkg::xlen_t     imm0, imm1,
    output decode_pkg::xlen_t     pc0_q, pc1_q,
    output decode_pkg::xlen_t     npc0, npc1
);
    import decode_pkg::*;

    logic      ready_s [2];
    xlen_t     pc_s [2];
    xlen_t     instr_s [2];

    logic      valid_q [2];
    logic      exception_q [2];
    op_class_t op_class_q [2];
    alu_op_t   alu_op_q [2];
    cond_t     cond_q [2];
    reg_addr_t waddr_q [2];
    reg_addr_t raddr1_q [2];
    reg_addr_t raddr2_q [2];
    logic      wren_q [2];
    logic      rden1_q [2];
    logic      rden2_q [2];
    xlen_t     imm_q [2];
    xlen_t     pc_q [2];
    xlen_t     npc_q [2];

    assign ready_s = '{ready0, ready1};
    assign pc_s    = '{pc0, pc1};
    assign instr_s = '{instr0, instr1};

    for (genvar s = 0; s < 2; s++) begin : slot
        xlen_t     word;
        xlen_t     pc_sel;
        logic      illegal;
        logic      b_valid;
        logic      b_wren;
        logic      b_rden1;
        logic      b_rden2;
        op_class_t b_op_class;
        alu_op_t   b_alu_op;
        cond_t     b_cond;
        xlen_t     b_imm;
        logic      c_valid;
        logic      c_wren;
        logic      c_rden1;
        logic      c_rden2;
        op_class_t c_op_class;
        alu_op_t   c_alu_op;
        cond_t     c_cond;
        reg_addr_t c_waddr;
        reg_addr_t c_raddr1;
        reg_addr_t c_raddr2;
        xlen_t     c_imm;

        assign pc_sel  = ready_s[s] ? pc_s[s] : invalid_pc;
        assign word    = ready_s[s] ? instr_s[s] : init_xlen;   // idle slot decodes zero
        assign illegal = !(b_valid || c_valid);

        base_decoder base_dec (
            .instr(word),
            .dec_valid(b_valid),
            .wren(b_wren), .rden1(b_rden1), .rden2(b_rden2),
            .op_class(b_op_class), .alu_op(b_alu_op), .cond(b_cond),
            .imm(b_imm)
        );

        compress_decoder comp_dec (
            .instr(word),
            .dec_valid(c_valid),
            .wren(c_wren), .rden1(c_rden1), .rden2(c_rden2),
            .op_class(c_op_class), .alu_op(c_alu_op), .cond(c_cond),
            .waddr(c_waddr), .raddr1(c_raddr1), .raddr2(c_raddr2),
            .imm(c_imm)
        );

        // an illegal word falls through to the base fields, which are op_none, no enables
        always_ff @(posedge clock) begin
            if (!reset || clear) begin
                valid_q[s]     <= 1'b0;
                exception_q[s] <= 1'b0;
                op_class_q[s]  <= init_op_class;
                alu_op_q[s]    <= init_alu_op;
                cond_q[s]      <= init_cond;
                waddr_q[s]     <= init_addr;
                raddr1_q[s]    <= init_addr;
                raddr2_q[s]    <= init_addr;
                wren_q[s]      <= 1'b0;
                rden1_q[s]     <= 1'b0;
                rden2_q[s]     <= 1'b0;
                imm_q[s]       <= init_xlen;
                pc_q[s]        <= init_xlen;
                npc_q[s]       <= init_xlen;
            end else begin
                valid_q[s]     <= ready_s[s];
                exception_q[s] <= ready_s[s] && illegal;
                op_class_q[s]  <= c_valid ? c_op_class : b_op_class;
                alu_op_q[s]    <= c_valid ? c_alu_op : b_alu_op;
                cond_q[s]      <= c_valid ? c_cond : b_cond;
                waddr_q[s]     <= c_valid ? c_waddr : word[11:7];
                raddr1_q[s]    <= c_valid ? c_raddr1 : word[19:15];
                raddr2_q[s]    <= c_valid ? c_raddr2 : word[24:20];
                wren_q[s]      <= c_valid ? c_wren : b_wren;
                rden1_q[s]     <= c_valid ? c_rden1 : b_rden1;
                rden2_q[s]     <= c_valid ? c_rden2 : b_rden2;
                imm_q[s]       <= c_valid ? c_imm : b_imm;
                pc_q[s]        <= pc_sel;
                npc_q[s]       <= pc_sel + ((&word[1:0]) ? 32'd4 : 32'd2);
            end
        end
    end

    assign {valid0, valid1}         = {valid_q[0], valid_q[1]};
    assign {exception0, exception1} = {exception_q[0], exception_q[1]};
    assign op_class0                = op_class_q[0];
    assign op_class1                = op_class_q[1];
    assign alu_op0                  = alu_op_q[0];
    assign alu_op1                  = alu_op_q[1];
    assign {cond0, cond1}           = {cond_q[0], cond_q[1]};
    assign {waddr0, waddr1}         = {waddr_q[0], waddr_q[1]};
    assign {raddr10, raddr11}       = {raddr1_q[0], raddr1_q[1]};
    assign {raddr20, raddr21}       = {raddr2_q[0], raddr2_q[1]};
    assign {wren0, wren1}           = {wren_q[0], wren_q[1]};
    assign {rden10, rden11}         = {rden1_q[0], rden1_q[1]};
    assign {rden20, rden21}         = {rden2_q[0], rden2_q[1]};
    assign {imm0, imm1}             = {imm_q[0], imm_q[1]};
    assign {pc0_q, pc1_q}           = {pc_q[0], pc_q[1]};
    assign {npc0, npc1}             = {npc_q[0], npc_q[1]};

endmodule

`default_nettype wire

// File: hw/decode_unit.sv
`default_nettype none

module decode_unit #(
    parameter decode_pkg::xlen_t invalid_pc = '1
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  clear,
    input  logic                  ready0, ready1,
    input  decode_pkg::xlen_t     pc0, pc1,
    input  decode_pkg::xlen_t     instr0, instr1,
    output logic                  valid0, valid1,
    output logic                  exception0, exception1,
    output decode_pkg::op_class_t op_class0, op_class1,
    output decode_pkg::alu_op_t   alu_op0, alu_op1,
    output decode_pkg::cond_t     cond0, cond1,
    output decode_pkg::reg_addr_t waddr0, waddr1,
    output decode_pkg::reg_addr_t raddr10, raddr11,
    output decode_pkg::reg_addr_t raddr20, raddr21,
    output logic                  wren0, wren1,
    output logic                  rden10, rden11,
    output logic                  rden20, rden21,
    output decode_pkg::xlen_t     imm0, imm1,
    output decode_pkg::xlen_t     pc0_q, pc1_q,
    output decode_pkg::xlen_t     npc0, npc1
);

    decode_stage #(
        .invalid_pc(invalid_pc)
    ) decode_stage_inst (
        .clock(clock), .reset(reset), .clear(clear),
        .ready0(ready0), .ready1(ready1),
        .pc0(pc0), .pc1(pc1),
        .instr0(instr0), .instr1(instr1),
        .valid0(valid0), .valid1(valid1),
        .exception0(exception0), .exception1(exception1),
        .op_class0(op_class0), .op_class1(op_class1),
        .alu_op0(alu_op0), .alu_op1(alu_op1),
        .cond0(cond0), .cond1(cond1),
        .waddr0(waddr0), .waddr1(waddr1),
        .raddr10(raddr10), .raddr11(raddr11),
        .raddr20(raddr20), .raddr21(raddr21),
        .wren0(wren0), .wren1(wren1),
        .rden10(rden10), .rden11(rden11),
        .rden20(rden20), .rden21(rden21),
        .imm0(imm0), .imm1(imm1),
        .pc0_q(pc0_q), .pc1_q(pc1_q),
        .npc0(npc0), .npc1(npc1)
    );

endmodule

`default_nettype wire

// File: sim/decode_unit_chk.sv
`default_nettype none

module decode_unit_chk (
    input logic clock,
    input logic reset,
    input logic clear,
    input logic valid0,
    input logic valid1,
    input logic exception0,
    input logic exception1
);

    a_reset_idle: assert property (@(posedge clock) !reset |=> !valid0 && !valid1)
        else $error("valid set after a reset cycle");

    a_exc0_valid: assert property (@(posedge clock) exception0 |-> valid0)
        else $error("slot 0 exception without valid");

    a_exc1_valid: assert property (@(posedge clock) exception1 |-> valid1)
        else $error("slot 1 exception without valid");

    // flush empties both slots
    a_clear: assert property (@(posedge clock) disable iff (!reset) clear |=> !valid0 && !valid1)
        else $error("valid set after clear");

endmodule

bind decode_stage decode_unit_chk decode_unit_chk_inst (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .valid0(valid0),
    .valid1(valid1),
    .exception0(exception0),
    .exception1(exception1)
);

`default_nettype wire

// File: sim/decode_unit_tb.sv
`default_nettype none

module decode_unit_tb;
    import decode_pkg::*;

    localparam xlen_t invalid_pc    = 32'h0bad_0ffc;
    localparam int    num_cycles    = 3000;
    localparam int    reset_timeout = 50;

    typedef struct packed {
        logic      valid;
        logic      exception;
        op_class_t op_class;
        alu_op_t   alu_op;
        cond_t     cond;
        reg_addr_t waddr;
        reg_addr_t raddr1;
        reg_addr_t raddr2;
        logic      wren;
        logic      rden1;
        logic      rden2;
        xlen_t     imm;
        xlen_t     pc;
        xlen_t     npc;
    } slot_t;

    logic      clock, reset, clear, ready0, ready1;
    xlen_t     pc0, pc1, instr0, instr1;
    logic      valid0, valid1, exception0, exception1;
    op_class_t op_class0, op_class1;
    alu_op_t   alu_op0, alu_op1;
    cond_t     cond0, cond1;
    reg_addr_t waddr0, waddr1, raddr10, raddr11, raddr20, raddr21;
    logic      wren0, wren1, rden10, rden11, rden20, rden21;
    xlen_t     imm0, imm1, pc0_q, pc1_q, npc0, npc1;

    logic [31:0] lfsr;
    int          errors;
    logic        pend_ok;
    slot_t       exp0, exp1;

    decode_unit #(.invalid_pc(invalid_pc)) decode_unit_inst (.*);

    always #20 clock = ~clock;

    // galois lfsr stepped once per bit
    function automatic xlen_t rand_bits(input int n);
        xlen_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic xlen_t sext(input xlen_t v, input int n);
        return xlen_t'($signed(v << (32 - n)) >>> (32 - n));
    endfunction

    function automatic xlen_t gen_word();
        xlen_t w;
        xlen_t k;
        k = rand_bits(3);
        w = rand_bits(32);
        if (k < 3) begin
            case (rand_bits(4) % 9)
                0: w[6:0] = 7'h37;
                1: w[6:0] = 7'h17;
                2: w[6:0] = 7'h6f;
                3: begin
                    w[6:0]   = 7'h67;
                    w[14:12] = 3'b000;
                end
                4: w[6:0] = 7'h63;
                5: begin
                    w[6:0]   = 7'h03;
                    w[14:12] = 3'b010;
                end
                6: begin
                    w[6:0]   = 7'h23;
                    w[14:12] = 3'b010;
                end
                7: w[6:0] = 7'h13;
                default: w[6:0] = 7'h33;
            endcase
            if (rand_bits(1) == 0)
                w[31:25] = 7'h00;
        end else if (k < 6) begin
            case (rand_bits(3))
                0: {w[15:13], w[1:0]} = 5'b010_00;     // c.lw
                1: {w[15:13], w[1:0]} = 5'b110_00;     // c.sw
                2: {w[15:13], w[1:0]} = 5'b000_01;     // c.addi
                3: {w[15:13], w[1:0]} = 5'b010_01;     // c.li
                4: {w[15:13], w[1:0]} = 5'b101_01;     // c.j
                5: {w[15:13], w[1:0]} = 5'b110_01;     // c.beqz
                default: {w[15:13], w[1:0]} = 5'b100_10;   // c.mv / c.add
            endcase
        end else if (k == 7 && rand_bits(1) == 0) begin
            w = '0;
        end
        return w;
    endfunction

    function automatic slot_t expect_slot(input logic rdy, input xlen_t pc, input xlen_t ins,
                                          input logic clr);
        slot_t      e;
        xlen_t      w;
        logic       ok;
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        e = '0;
        e.op_class = op_none;
        e.alu_op   = alu_add;
        if (clr)
            return e;
        w   = rdy ? ins : '0;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        ok  = 1'b1;
        e.pc  = rdy ? pc : invalid_pc;
        e.npc = e.pc + ((w[1:0] == 2'b11) ? 32'd4 : 32'd2);
        if (w[1:0] == 2'b11) begin
            e.waddr  = w[11:7];
            e.raddr1 = w[19:15];
            e.raddr2 = w[24:20];
            case (opc)
                7'h37, 7'h17: begin
                    e.op_class = (opc == 7'h37) ? op_lui : op_auipc;
                    e.imm      = {w[31:12], 12'h000};
                    e.wren     = 1'b1;
                end
                7'h6f: begin
                    e.op_class = op_jal;
                    e.imm      = sext({11'b0, w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
                    e.wren     = 1'b1;
                end
                7'h67: begin
                    ok = (f3 == 3'b000);
                    e.op_class = op_jalr;
                    e.imm      = sext({20'b0, w[31:20]}, 12);
                    {e.wren, e.rden1} = 2'b11;
                end
                7'h63: begin
                    ok = (f3 != 3'b010) && (f3 != 3'b011);
                    e.op_class = op_branch;
                    e.cond     = f3;
                    e.alu_op   = (f3 < 4) ? alu_sub : ((f3 < 6) ? alu_slt : alu_sltu);
                    e.imm      = sext({19'b0, w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
                    {e.rden1, e.rden2} = 2'b11;
                end
                7'h03: begin
                    ok = (f3 == 3'b010);
                    e.op_class = op_load;
                    e.imm      = sext({20'b0, w[31:20]}, 12);
                    {e.wren, e.rden1} = 2'b11;
                end
                7'h23: begin
                    ok = (f3 == 3'b010);
                    e.op_class = op_store;
                    e.imm      = sext({20'b0, w[31:25], w[11:7]}, 12);
                    {e.rden1, e.rden2} = 2'b11;
                end
                7'h13, 7'h33: begin
                    if (opc == 7'h33)
                        ok = (f7 == 0) || (f7 == 7'h20 && (f3 == 0 || f3 == 5));
                    else if (f3 == 1)
                        ok = (f7 == 0);
                    else if (f3 == 5)
                        ok = (f7 == 0) || (f7 == 7'h20);
                    case (f3)
                        0: e.alu_op = (opc == 7'h33 && f7 == 7'h20) ? alu_sub : alu_add;
                        1: e.alu_op = alu_sll;
                        2: e.alu_op = alu_slt;
                        3: e.alu_op = alu_sltu;
                        4: e.alu_op = alu_xor;
                        5: e.alu_op = (f7 == 7'h20) ? alu_sra : alu_srl;
                        6: e.alu_op = alu_or;
                        default: e.alu_op = alu_and;
                    endcase
                    e.op_class = op_alu;
                    e.imm      = (opc == 7'h13) ? sext({20'b0, w[31:20]}, 12) : '0;
                    {e.wren, e.rden1, e.rden2} = {2'b11, opc == 7'h33};
                end
                default: ok = 1'b0;
            endcase
        end else begin
            case ({w[15:13], w[1:0]})
                5'b010_00, 5'b110_00: begin
                    e.op_class = w[15] ? op_store : op_load;
                    e.raddr1   = {2'b01, w[9:7]};
                    e.imm      = {25'b0, w[5], w[12:10], w[6], 2'b00};
                    if (w[15])
                        {e.raddr2, e.rden1, e.rden2} = {2'b01, w[4:2], 2'b11};
                    else
                        {e.waddr, e.wren, e.rden1} = {2'b01, w[4:2], 2'b11};
                end
                5'b000_01, 5'b010_01: begin
                    e.op_class = op_alu;
                    e.waddr    = w[11:7];
                    e.raddr1   = w[14] ? 5'd0 : w[11:7];   // c.li adds to x0
                    e.imm      = sext({26'b0, w[12], w[6:2]}, 6);
                    {e.wren, e.rden1} = 2'b11;
                end
                5'b101_01: begin
                    e.op_class = op_jal;
                    e.imm      = sext({20'b0, w[12], w[8], w[10:9], w[6], w[7], w[2], w[11],
                                       w[5:3], 1'b0}, 12);
                    e.wren     = 1'b1;
                end
                5'b110_01: begin
                    e.op_class = op_branch;
                    e.alu_op   = alu_sub;
                    e.raddr1   = {2'b01, w[9:7]};
                    e.imm      = sext({23'b0, w[12], w[6:5], w[2], w[11:10], w[4:3], 1'b0}, 9);
                    {e.rden1, e.rden2} = 2'b11;
                end
                5'b100_10: begin
                    ok = (w[6:2] != 0);
                    e.op_class = op_alu;
                    e.waddr    = w[11:7];
                    e.raddr1   = w[12] ? w[11:7] : 5'd0;
                    e.raddr2   = w[6:2];
                    {e.wren, e.rden1, e.rden2} = 3'b111;
                end
                default: ok = 1'b0;
            endcase
        end
        if (!ok) begin
            e.op_class = op_none;
            e.alu_op   = alu_add;
            e.cond     = '0;
            e.imm      = '0;
            {e.wren, e.rden1, e.rden2} = 3'b000;
            e.waddr    = w[11:7];
            e.raddr1   = w[19:15];
            e.raddr2   = w[24:20];
        end
        e.valid     = rdy;
        e.exception = rdy && !ok;
        return e;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_class(input string name, input op_class_t got, input op_class_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_alu(input string name, input alu_op_t got, input alu_op_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_cond(input string name, input cond_t got, input cond_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_slot(input string s, input slot_t e, input logic v, input logic x,
                              input op_class_t oc, input alu_op_t ao, input cond_t c,
                              input reg_addr_t wa, input reg_addr_t r1, input reg_addr_t r2,
                              input logic we, input logic re1, input logic re2,
                              input xlen_t im, input xlen_t p, input xlen_t np);
        check_bit({s, ".valid"}, v, e.valid);
        check_bit({s, ".exception"}, x, e.exception);
        check_class({s, ".op_class"}, oc, e.op_class);
        check_alu({s, ".alu_op"}, ao, e.alu_op);
        check_cond({s, ".cond"}, c, e.cond);
        check_addr({s, ".waddr"}, wa, e.waddr);
        check_addr({s, ".raddr1"}, r1, e.raddr1);
        check_addr({s, ".raddr2"}, r2, e.raddr2);
        check_bit({s, ".wren"}, we, e.wren);
        check_bit({s, ".rden1"}, re1, e.rden1);
        check_bit({s, ".rden2"}, re2, e.rden2);
        check_xlen({s, ".imm"}, im, e.imm);
        check_xlen({s, ".pc"}, p, e.pc);
        check_xlen({s, ".npc"}, np, e.npc);
    endtask

    task automatic drive_inputs();
        ready0 = (rand_bits(2) != 0);
        ready1 = (rand_bits(2) != 0);
        pc0    = rand_bits(32) & ~32'h1;
        pc1    = rand_bits(32) & ~32'h1;
        instr0 = gen_word();
        instr1 = gen_word();
        clear  = (rand_bits(4) == 0);
        exp0   = expect_slot(ready0, pc0, instr0, clear || !reset);
        exp1   = expect_slot(ready1, pc1, instr1, clear || !reset);
        pend_ok = 1'b1;
    endtask

    // results of the previous edge's inputs
    always @(posedge clock) begin
        #1;
        if (pend_ok) begin
            check_slot("slot0", exp0, valid0, exception0, op_class0, alu_op0, cond0, waddr0,
                       raddr10, raddr20, wren0, rden10, rden20, imm0, pc0_q, npc0);
            check_slot("slot1", exp1, valid1, exception1, op_class1, alu_op1, cond1, waddr1,
                       raddr11, raddr21, wren1, rden11, rden21, imm1, pc1_q, npc1);
        end
    end

    initial begin
        reset = 1'b0;
        repeat (5) @(posedge clock);
        #1 reset = 1'b1;
    end

    initial begin
        int wait_count;
        clock   = 1'b0;
        clear   = 1'b0;
        ready0  = 1'b0;
        ready1  = 1'b0;
        pc0     = '0;
        pc1     = '0;
        instr0  = '0;
        instr1  = '0;
        lfsr    = 32'he27d39f1;
        errors  = 0;
        pend_ok = 1'b0;
        wait_count = 0;
        while (reset !== 1'b1 && wait_count < reset_timeout) begin
            @(posedge clock);
            #2;
            drive_inputs();
            wait_count++;
        end
        if (reset !== 1'b1) begin
            $display("timeout: reset was never released");
            $display("Finished with errors");
        end else begin
            for (int cyc = 0; cyc < num_cycles; cyc++) begin
                @(posedge clock);
                #2;
                drive_inputs();
            end
            @(posedge clock);
            #2;
            $display("errors: %0d", errors);
            if (errors == 0)
                $display("Finished with no errors");
            else
                $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
common/decode_pkg.sv
hw/base_decoder.sv
hw/compress_decoder.sv
decode_stage/decode_stage.sv
hw/decode_unit.sv
sim/decode_unit_chk.sv
sim/decode_unit_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = decode_unit_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir

SOURCES = $(shell grep -v '^+' $(FILELIST))
BIN     = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -qx "Finished with no errors"

clean:
	rm -rf $(OBJ_DIR)
